/* src/sm83_types_pkg.sv */
package sm83_types_pkg;

  // Interrupt register window
  localparam logic [15:0] IF_ADDR = 16'hFF0F;
  localparam logic [15:0] IE_ADDR = 16'hFFFF;

  localparam logic [15:0] RESET_SP = 16'hFFFE;  // Stack pointer after reset

  // Bit positions inside the F register
  localparam int FLAG_Z = 7;
  localparam int FLAG_N = 6;
  localparam int FLAG_H = 5;
  localparam int FLAG_C = 4;

  // Clock phase within one machine cycle
  typedef enum logic [1:0] {
    T1,
    T2,
    T3,
    T4
  } t_phase_t;

  // Register pair that drives the address bus
  typedef enum logic [2:0] {
    ADDR_NONE,
    ADDR_PC,
    ADDR_SP,
    ADDR_HL,
    ADDR_WZ
  } addr_src_t;

  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        read_en;
    logic        write_en;
  } mem_req_t;

  // One request pulse per source, vblank in bit 0
  typedef struct packed {
    logic joypad;
    logic serial;
    logic timer;
    logic stat;
    logic vblank;
  } irq_req_t;

  typedef struct packed {
    logic [7:0] a;
    logic [7:0] flags;
    logic [7:0] b;
    logic [7:0] c;
    logic [7:0] h;
    logic [7:0] l;
    logic [7:0] w;    // Temporary high byte
    logic [7:0] z;    // Temporary low byte
    logic [7:0] sph;
    logic [7:0] spl;
    logic [7:0] pch;
    logic [7:0] pcl;
    logic [7:0] ir;   // Opcode of the next instruction
    logic       ime;  // Interrupt master enable
  } cpu_regs_t;

endpackage

/* src/sm83_ucode_pkg.sv */
package sm83_ucode_pkg;

  localparam int MAX_CYCLES = 5;  // Longest control word, the interrupt entry

  typedef enum logic [7:0] {
    OP_NOP      = 8'h00,
    OP_LD_B_N   = 8'h06,
    OP_LD_HL_NN = 8'h21,
    OP_INC_A    = 8'h3C,
    OP_LD_A_N   = 8'h3E,
    OP_LD_HL_A  = 8'h77,
    OP_LD_A_HL  = 8'h7E,
    OP_ADD_A_B  = 8'h80,
    OP_JP_NN    = 8'hC3,
    OP_DI       = 8'hF3,
    OP_EI       = 8'hFB
  } opcode_t;

  typedef enum logic [1:0] {BUS_NONE, BUS_READ, BUS_WRITE} bus_op_t;

  typedef enum logic [3:0] {
    REG_A, REG_B, REG_H, REG_L, REG_W, REG_Z, REG_IR, REG_PCH, REG_PCL
  } bus_reg_t;

  typedef enum logic [1:0] {IDU_NONE, IDU_INC, IDU_DEC} idu_op_t;

  typedef enum logic [1:0] {ALU_NONE, ALU_INC, ALU_ADD} alu_op_t;

  typedef enum logic [2:0] {
    MISC_NONE, MISC_LD_A_Z, MISC_LD_B_Z, MISC_LD_HL_WZ,
    MISC_JP_WZ, MISC_EI, MISC_DI, MISC_VECTOR
  } misc_op_t;

  typedef struct packed {
    sm83_types_pkg::addr_src_t addr_src;
    bus_op_t                   bus_op;
    bus_reg_t                  bus_reg;  // Load target or store source
    idu_op_t                   idu_op;   // Applied to the addr_src pair in T4
    alu_op_t                   alu_op;
    misc_op_t                  misc_op;
  } m_cycle_t;

  typedef struct packed {
    logic [2:0]                  num_cycles;
    m_cycle_t [MAX_CYCLES-1:0]   cycles;
  } control_word_t;

  function automatic m_cycle_t mcycle(input sm83_types_pkg::addr_src_t src,
                                      input bus_op_t op, input bus_reg_t breg,
                                      input idu_op_t idu, input alu_op_t alu,
                                      input misc_op_t misc);
    m_cycle_t mc;
    mc.addr_src = src;
    mc.bus_op   = op;
    mc.bus_reg  = breg;
    mc.idu_op   = idu;
    mc.alu_op   = alu;
    mc.misc_op  = misc;
    return mc;
  endfunction

  // Overlapped opcode fetch, always the last cycle of a word
  function automatic m_cycle_t fetch(input alu_op_t alu, input misc_op_t misc);
    return mcycle(sm83_types_pkg::ADDR_PC, BUS_READ, REG_IR, IDU_INC, alu, misc);
  endfunction

  function automatic m_cycle_t imm_read(input bus_reg_t breg);
    return mcycle(sm83_types_pkg::ADDR_PC, BUS_READ, breg, IDU_INC, ALU_NONE, MISC_NONE);
  endfunction

  function automatic control_word_t decode_word(input logic [7:0] op_byte);
    control_word_t cw;
    cw = '0;
    case (opcode_t'(op_byte))
      OP_LD_A_N, OP_LD_B_N: begin
        cw.num_cycles = 3'd2;
        cw.cycles[0]  = imm_read(REG_Z);
        cw.cycles[1]  = fetch(ALU_NONE, (op_byte == OP_LD_A_N) ? MISC_LD_A_Z : MISC_LD_B_Z);
      end
      OP_LD_HL_NN: begin
        cw.num_cycles = 3'd3;
        cw.cycles[0]  = imm_read(REG_Z);  // Low byte first
        cw.cycles[1]  = imm_read(REG_W);
        cw.cycles[2]  = fetch(ALU_NONE, MISC_LD_HL_WZ);
      end
      OP_LD_HL_A: begin
        cw.num_cycles = 3'd2;
        cw.cycles[0]  = mcycle(sm83_types_pkg::ADDR_HL, BUS_WRITE, REG_A, IDU_NONE,
                               ALU_NONE, MISC_NONE);
        cw.cycles[1]  = fetch(ALU_NONE, MISC_NONE);
      end
      OP_LD_A_HL: begin
        cw.num_cycles = 3'd2;
        cw.cycles[0]  = mcycle(sm83_types_pkg::ADDR_HL, BUS_READ, REG_A, IDU_NONE,
                               ALU_NONE, MISC_NONE);
        cw.cycles[1]  = fetch(ALU_NONE, MISC_NONE);
      end
      OP_INC_A: begin
        cw.num_cycles = 3'd1;
        cw.cycles[0]  = fetch(ALU_INC, MISC_NONE);
      end
      OP_ADD_A_B: begin
        cw.num_cycles = 3'd1;
        cw.cycles[0]  = fetch(ALU_ADD, MISC_NONE);
      end
      OP_JP_NN: begin
        cw.num_cycles = 3'd4;
        cw.cycles[0]  = imm_read(REG_Z);
        cw.cycles[1]  = imm_read(REG_W);
        cw.cycles[2]  = mcycle(sm83_types_pkg::ADDR_NONE, BUS_NONE, REG_A, IDU_NONE,
                               ALU_NONE, MISC_JP_WZ);  // Internal cycle, PC takes WZ
        cw.cycles[3]  = fetch(ALU_NONE, MISC_NONE);
      end
      OP_DI, OP_EI: begin
        cw.num_cycles = 3'd1;
        cw.cycles[0]  = fetch(ALU_NONE, (op_byte == OP_EI) ? MISC_EI : MISC_DI);
      end
      default: begin  // OP_NOP and every opcode outside the subset
        cw.num_cycles = 3'd1;
        cw.cycles[0]  = fetch(ALU_NONE, MISC_NONE);
      end
    endcase
    return cw;
  endfunction

  // Interrupt entry; the core parks the vector low byte in Z before it starts
  function automatic control_word_t irq_word(input logic [2:0] idx);
    control_word_t cw;
    cw = '0;
    if (idx < 3'd5) begin
      cw.num_cycles = 3'd5;
      cw.cycles[0]  = mcycle(sm83_types_pkg::ADDR_PC, BUS_NONE, REG_A, IDU_DEC,
                             ALU_NONE, MISC_NONE);  // Undo the discarded prefetch
      cw.cycles[1]  = mcycle(sm83_types_pkg::ADDR_SP, BUS_NONE, REG_A, IDU_DEC,
                             ALU_NONE, MISC_NONE);
      cw.cycles[2]  = mcycle(sm83_types_pkg::ADDR_SP, BUS_WRITE, REG_PCH, IDU_DEC,
                             ALU_NONE, MISC_NONE);
      cw.cycles[3]  = mcycle(sm83_types_pkg::ADDR_SP, BUS_WRITE, REG_PCL, IDU_NONE,
                             ALU_NONE, MISC_VECTOR);
      cw.cycles[4]  = fetch(ALU_NONE, MISC_NONE);
    end else begin
      cw.num_cycles = 3'd1;  // No such source, behave as NOP
      cw.cycles[0]  = fetch(ALU_NONE, MISC_NONE);
    end
    return cw;
  endfunction

endpackage

/* src/sm83_alu.sv */
module sm83_alu (
  input  sm83_ucode_pkg::alu_op_t op,
  input  logic [7:0]              a,
  input  logic [7:0]              b,
  input  logic [7:0]              flags_in,
  output logic [7:0]              result,
  output logic [7:0]              flags_out
);
  import sm83_types_pkg::*;
  import sm83_ucode_pkg::*;

  logic [8:0] sum;       // Full add with carry out
  logic [4:0] half_sum;  // Low nibble add for H

  assign sum      = {1'b0, a} + {1'b0, b};
  assign half_sum = {1'b0, a[3:0]} + {1'b0, b[3:0]};

  always_comb begin
    result    = a;
    flags_out = flags_in;
    case (op)
      ALU_INC: begin
        result            = a + 8'd1;
        flags_out[FLAG_Z] = (result == 8'h00);
        flags_out[FLAG_N] = 1'b0;
        flags_out[FLAG_H] = (a[3:0] == 4'hF);
        flags_out[3:0]    = 4'h0;  // C left as it was
      end
      ALU_ADD: begin
        result            = sum[7:0];
        flags_out[FLAG_Z] = (sum[7:0] == 8'h00);
        flags_out[FLAG_N] = 1'b0;
        flags_out[FLAG_H] = half_sum[4];
        flags_out[FLAG_C] = sum[8];
        flags_out[3:0]    = 4'h0;
      end
      default: begin
        result    = a;
        flags_out = flags_in;
      end
    endcase
  end

endmodule

/* src/interrupt_ctrl.sv */
module interrupt_ctrl (
  input  logic                     clk,
  input  logic                     reset,
  input  sm83_types_pkg::mem_req_t bus,
  output logic [7:0]               rdata,
  input  sm83_types_pkg::irq_req_t irq,
  input  logic                     irq_ack,
  output logic                     irq_pending,
  output logic [2:0]               irq_index
);
  import sm83_types_pkg::*;

  logic [4:0] if_bits;  // Bits 7:5 of IF are not stored
  logic [4:0] if_next;
  logic [7:0] ie_reg;
  logic [4:0] pending;

  always_comb begin
    if_next = if_bits;
    if (bus.write_en && bus.addr == IF_ADDR) if_next = bus.wdata[4:0];
    if_next = if_next | irq;                  // New requests
    if (irq_ack) if_next[irq_index] = 1'b0;   // Ack beats a same-cycle request
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      if_bits <= 5'b00000;
      ie_reg  <= 8'h00;
    end else begin
      if_bits <= if_next;
      if (bus.write_en && bus.addr == IE_ADDR) ie_reg <= bus.wdata;
    end
  end

  assign rdata = (bus.addr == IE_ADDR) ? ie_reg : {3'b111, if_bits};

  assign pending     = if_bits & ie_reg[4:0];
  assign irq_pending = |pending;

  // Lowest set bit has priority, vblank first
  always_comb begin
    irq_index = 3'd0;
    for (int i = 4; i >= 0; i--) begin
      if (pending[i]) irq_index = 3'(i);
    end
  end

endmodule

/* src/gb_bus_map.sv */
module gb_bus_map (
  input  sm83_types_pkg::mem_req_t cpu_bus,
  output logic [7:0]               cpu_rdata,
  output sm83_types_pkg::mem_req_t mem,
  input  logic [7:0]               mem_rdata,
  output sm83_types_pkg::mem_req_t intc_bus,
  input  logic [7:0]               intc_rdata
);
  import sm83_types_pkg::*;

  logic in_window;  // IF or IE selected

  assign in_window = (cpu_bus.addr == IF_ADDR) || (cpu_bus.addr == IE_ADDR);

  // Address and data go to both sides, enables to one
  always_comb begin
    mem      = cpu_bus;
    intc_bus = cpu_bus;
    if (in_window) begin
      mem.read_en  = 1'b0;
      mem.write_en = 1'b0;
    end else begin
      intc_bus.read_en  = 1'b0;
      intc_bus.write_en = 1'b0;
    end
  end

  assign cpu_rdata = in_window ? intc_rdata : mem_rdata;

endmodule

/* src/sm83_core.sv */
module sm83_core (
  input  logic                     clk,
  input  logic                     reset,
  output sm83_types_pkg::mem_req_t bus,
  input  logic [7:0]               rdata,
  input  logic                     irq_pending,
  input  logic [2:0]               irq_index,
  output logic                     irq_ack,
  output sm83_ucode_pkg::alu_op_t  alu_op,
  output logic [7:0]               alu_a,
  output logic [7:0]               alu_b,
  output logic [7:0]               alu_flags,
  input  logic [7:0]               alu_result,
  input  logic [7:0]               alu_flags_new
);
  import sm83_types_pkg::*;
  import sm83_ucode_pkg::*;

  cpu_regs_t     regs;
  control_word_t control_word;  // Instruction being executed
  logic [2:0]    cycle;         // Machine cycle within the word
  t_phase_t      t_phase;
  m_cycle_t      cur;
  logic          last_cycle;
  logic          take_irq;
  logic [15:0]   src_addr;      // Selected register pair
  logic [15:0]   idu_out;

  function automatic logic [7:0] reg_byte(input bus_reg_t sel, input cpu_regs_t r);
    case (sel)
      REG_A:   return r.a;
      REG_B:   return r.b;
      REG_H:   return r.h;
      REG_L:   return r.l;
      REG_W:   return r.w;
      REG_Z:   return r.z;
      REG_IR:  return r.ir;
      REG_PCH: return r.pch;
      default: return r.pcl;
    endcase
  endfunction

  assign cur        = control_word.cycles[cycle];
  assign last_cycle = (cycle == control_word.num_cycles - 3'd1);

  // Dispatch only at a boundary; DI in the same cycle wins
  assign take_irq = (t_phase == T4) && last_cycle && regs.ime && irq_pending &&
                    (cur.misc_op != MISC_DI);
  assign irq_ack  = take_irq;

  assign alu_op    = cur.alu_op;
  assign alu_a     = regs.a;
  assign alu_b     = regs.b;
  assign alu_flags = regs.flags;

  always_comb begin
    case (cur.addr_src)
      ADDR_PC: src_addr = {regs.pch, regs.pcl};
      ADDR_SP: src_addr = {regs.sph, regs.spl};
      ADDR_HL: src_addr = {regs.h, regs.l};
      ADDR_WZ: src_addr = {regs.w, regs.z};
      default: src_addr = 16'h0000;
    endcase
    case (cur.idu_op)
      IDU_INC: idu_out = src_addr + 16'd1;
      IDU_DEC: idu_out = src_addr - 16'd1;
      default: idu_out = src_addr;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regs                 <= '0;
      {regs.sph, regs.spl} <= RESET_SP;
      control_word         <= decode_word(OP_NOP);  // First cycle fetches from 0000
      cycle                <= '0;
      t_phase              <= T1;
      bus                  <= '0;
    end else begin
      unique case (t_phase)
        T1: begin
          bus.addr <= src_addr;
          t_phase  <= T2;
        end
        T2: begin
          bus.read_en  <= (cur.bus_op == BUS_READ);
          bus.write_en <= (cur.bus_op == BUS_WRITE);
          if (cur.bus_op == BUS_WRITE) bus.wdata <= reg_byte(cur.bus_reg, regs);
          t_phase <= T3;
        end
        T3: begin
          if (cur.bus_op == BUS_READ) begin
            case (cur.bus_reg)
              REG_A:   regs.a   <= rdata;
              REG_B:   regs.b   <= rdata;
              REG_H:   regs.h   <= rdata;
              REG_L:   regs.l   <= rdata;
              REG_W:   regs.w   <= rdata;
              REG_Z:   regs.z   <= rdata;
              REG_IR:  regs.ir  <= rdata;
              REG_PCH: regs.pch <= rdata;
              default: regs.pcl <= rdata;
            endcase
          end
          t_phase <= T4;
        end
        T4: begin
          bus.read_en  <= 1'b0;
          bus.write_en <= 1'b0;
          if (cur.idu_op != IDU_NONE) begin
            case (cur.addr_src)
              ADDR_PC: {regs.pch, regs.pcl} <= idu_out;
              ADDR_SP: {regs.sph, regs.spl} <= idu_out;
              ADDR_HL: {regs.h, regs.l}     <= idu_out;
              ADDR_WZ: {regs.w, regs.z}     <= idu_out;
              default: ;
            endcase
          end
          if (cur.alu_op != ALU_NONE) begin
            regs.a     <= alu_result;
            regs.flags <= alu_flags_new;
          end
          case (cur.misc_op)
            MISC_LD_A_Z:   regs.a <= regs.z;
            MISC_LD_B_Z:   regs.b <= regs.z;
            MISC_LD_HL_WZ: {regs.h, regs.l} <= {regs.w, regs.z};
            MISC_JP_WZ:    {regs.pch, regs.pcl} <= {regs.w, regs.z};
            MISC_EI:       regs.ime <= 1'b1;
            MISC_DI:       regs.ime <= 1'b0;
            MISC_VECTOR:   {regs.pch, regs.pcl} <= {8'h00, regs.z};
            default: ;
          endcase
          if (last_cycle) begin
            cycle <= '0;
            if (take_irq) begin
              control_word <= irq_word(irq_index);
              regs.ime     <= 1'b0;
              regs.z       <= {2'b01, irq_index, 3'b000};  // 0040 + 8 * index
            end else begin
              control_word <= decode_word(regs.ir);
            end
          end else begin
            cycle <= cycle + 3'd1;
          end
          t_phase <= T1;
        end
      endcase
    end
  end

endmodule

/* src/gb_cpu_top.sv */
module gb_cpu_top (
  input  logic                     clk,
  input  logic                     reset,
  output sm83_types_pkg::mem_req_t mem,
  input  logic [7:0]               mem_rdata,
  input  sm83_types_pkg::irq_req_t irq
);
  import sm83_types_pkg::*;
  import sm83_ucode_pkg::*;

  mem_req_t   cpu_bus;
  mem_req_t   intc_bus;
  logic [7:0] cpu_rdata;
  logic [7:0] intc_rdata;
  logic       irq_pending;
  logic [2:0] irq_index;
  logic       irq_ack;

  // ALU operands and results
  alu_op_t    alu_op;
  logic [7:0] alu_a;
  logic [7:0] alu_b;
  logic [7:0] alu_flags;
  logic [7:0] alu_result;
  logic [7:0] alu_flags_new;

  sm83_core core (
    .clk(clk), .reset(reset), .bus(cpu_bus), .rdata(cpu_rdata),
    .irq_pending(irq_pending), .irq_index(irq_index), .irq_ack(irq_ack),
    .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .alu_flags(alu_flags),
    .alu_result(alu_result), .alu_flags_new(alu_flags_new)
  );

  sm83_alu alu (
    .op(alu_op), .a(alu_a), .b(alu_b), .flags_in(alu_flags),
    .result(alu_result), .flags_out(alu_flags_new)
  );

  gb_bus_map bus_map (
    .cpu_bus(cpu_bus), .cpu_rdata(cpu_rdata), .mem(mem), .mem_rdata(mem_rdata),
    .intc_bus(intc_bus), .intc_rdata(intc_rdata)
  );

  interrupt_ctrl intc (
    .clk(clk), .reset(reset), .bus(intc_bus), .rdata(intc_rdata), .irq(irq),
    .irq_ack(irq_ack), .irq_pending(irq_pending), .irq_index(irq_index)
  );

endmodule

/* verif/gb_cpu_props.sv */
module gb_cpu_props (
  input logic                     clk,
  input logic                     reset,
  input sm83_types_pkg::mem_req_t bus
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0;  // Read by the testbench at the end
  logic        en;              // Any bus enable

  assign en = bus.read_en | bus.write_en;

  one_enable: assert property (@(posedge clk) disable iff (reset)
    !(bus.read_en && bus.write_en))
    else begin
      $error("read_en and write_en are high together");
      fail_count++;
    end

  // Second high sample must be followed by low, first one by high
  two_clock_enable: assert property (@(posedge clk) disable iff (reset)
    en |=> (en == !$past(en, 2)))
    else begin
      $error("bus enable did not last exactly two clocks");
      fail_count++;
    end

  stable_while_enabled: assert property (@(posedge clk) disable iff (reset)
    en && $past(en) |-> $stable(bus.addr) && $stable(bus.wdata))
    else begin
      $error("addr or wdata changed while an enable was high");
      fail_count++;
    end

  quiet_in_reset: assert property (@(posedge clk)
    reset || $past(reset) |-> !bus.read_en && !bus.write_en)
    else begin
      $error("bus enable high during reset or the clock after it");
      fail_count++;
    end

endmodule

bind sm83_core gb_cpu_props props (.clk(clk), .reset(reset), .bus(bus));

/* verif/gb_cpu_tb.sv */
module gb_cpu_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import sm83_types_pkg::*;
  import sm83_ucode_pkg::*;

  localparam int EVENT_TIMEOUT = 400;  // Clocks without any bus activity
  localparam int SEARCH_LIMIT  = 64;   // Bus events scanned for one target

  localparam logic [7:0]  N1          = 8'h25;
  localparam logic [7:0]  N2          = 8'h3A;
  localparam logic [7:0]  READBACK    = 8'hA7;
  localparam logic [15:0] READ_ADDR   = 16'hD000;
  localparam logic [15:0] JUMP_TARGET = 16'h0020;
  localparam logic [15:0] VEC_BASE    = 16'h0040;
  localparam logic [7:0]  TIMER_MARK  = 8'h5A;
  localparam logic [7:0]  VBLANK_MARK = 8'h40;
  localparam logic [2:0]  VBLANK_IDX  = 3'd0;
  localparam logic [2:0]  TIMER_IDX   = 3'd2;

  typedef struct packed {
    logic        is_write;
    logic [15:0] addr;
    logic [7:0]  data;
  } bus_event_t;

  logic        clk;
  logic        reset;
  mem_req_t    mem;
  logic [7:0]  mem_rdata;
  irq_req_t    irq;

  logic [7:0]  mem_image [0:65535];
  bus_event_t  events[$];  // Bus transfers in order of appearance
  logic        prev_read;
  logic        prev_write;
  logic [15:0] load_ptr;    // Assembler output address
  logic [15:0] skip_lo;
  logic [15:0] skip_hi;
  logic [15:0] jp_operand_hi;
  logic [15:0] ei_main;
  logic [15:0] spin_main;
  logic [15:0] ei_timer;
  logic [15:0] spin_timer;
  logic [15:0] exp_sp;      // Expected stack pointer
  logic [7:0]  exp_a;
  irq_req_t    timer_req;
  irq_req_t    pair_req;
  int          skipped_fetches;
  int          errors;
  int          checks;
  int          tests_done;
  int          test_errors;
  int          seed;
  int          pulse_delay;

  gb_cpu_top dut (
    .clk(clk), .reset(reset), .mem(mem), .mem_rdata(mem_rdata), .irq(irq)
  );

  assign mem_rdata = mem_image[mem.addr];  // Memory is always ready

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic bus_event_t make_event(input logic w, input logic [15:0] a,
                                            input logic [7:0] d);
    bus_event_t ev;
    ev.is_write = w;
    ev.addr     = a;
    ev.data     = d;
    return ev;
  endfunction

  function automatic logic [15:0] vector_addr(input logic [2:0] idx);
    return VEC_BASE + {10'd0, idx, 3'b000};
  endfunction

  // Sampled mid-cycle, where the DUT outputs are settled
  always @(negedge clk) begin
    if (!reset) begin
      if (mem.read_en && !prev_read) begin
        events.push_back(make_event(1'b0, mem.addr, mem_rdata));
        if (mem.addr >= skip_lo && mem.addr <= skip_hi) skipped_fetches++;
      end
      if (mem.write_en && !prev_write) begin
        events.push_back(make_event(1'b1, mem.addr, mem.wdata));
        mem_image[mem.addr] = mem.wdata;
      end
    end
    prev_read  = mem.read_en;
    prev_write = mem.write_en;
  end

  task automatic emit_byte(input logic [7:0] b);
    mem_image[load_ptr] = b;
    load_ptr++;
  endtask

  task automatic op_only(input opcode_t op);
    emit_byte(op);
  endtask

  task automatic op_with_byte(input opcode_t op, input logic [7:0] n);
    emit_byte(op);
    emit_byte(n);
  endtask

  task automatic op_with_word(input opcode_t op, input logic [15:0] nn);
    emit_byte(op);
    emit_byte(nn[7:0]);  // Little endian
    emit_byte(nn[15:8]);
  endtask

  task automatic load_program();
    for (int i = 0; i < 65536; i++) mem_image[16'(i)] = i[15:8] ^ i[7:0];
    load_ptr = 16'h0000;
    op_with_byte(OP_LD_A_N, N1);
    op_with_byte(OP_LD_B_N, N2);
    op_only(OP_ADD_A_B);
    op_with_word(OP_LD_HL_NN, 16'hC000);
    op_only(OP_LD_HL_A);
    op_only(OP_INC_A);
    op_with_word(OP_LD_HL_NN, 16'hC001);
    op_only(OP_LD_HL_A);
    op_with_word(OP_LD_HL_NN, READ_ADDR);
    op_only(OP_LD_A_HL);
    op_only(OP_INC_A);
    op_with_word(OP_LD_HL_NN, 16'hC002);
    op_only(OP_LD_HL_A);
    jp_operand_hi = load_ptr + 16'd2;
    op_with_word(OP_JP_NN, JUMP_TARGET);
    skip_lo  = load_ptr;
    skip_hi  = JUMP_TARGET - 16'd1;
    load_ptr = JUMP_TARGET;
    op_with_byte(OP_LD_A_N, 8'h04);  // Timer only
    op_with_word(OP_LD_HL_NN, IE_ADDR);
    op_only(OP_LD_HL_A);
    ei_main = load_ptr;
    op_only(OP_EI);
    spin_main = load_ptr;
    op_with_word(OP_JP_NN, spin_main);
    load_ptr = vector_addr(VBLANK_IDX);
    op_with_byte(OP_LD_A_N, VBLANK_MARK);
    op_with_word(OP_LD_HL_NN, 16'hC012);
    op_only(OP_LD_HL_A);
    op_with_word(OP_JP_NN, load_ptr);
    load_ptr = vector_addr(TIMER_IDX);
    op_with_byte(OP_LD_A_N, TIMER_MARK);
    op_with_word(OP_LD_HL_NN, 16'hC010);
    op_only(OP_LD_HL_A);
    op_with_word(OP_LD_HL_NN, IF_ADDR);
    op_only(OP_LD_A_HL);
    op_with_word(OP_LD_HL_NN, 16'hC011);
    op_only(OP_LD_HL_A);
    op_with_byte(OP_LD_A_N, 8'h1F);  // Every source enabled
    op_with_word(OP_LD_HL_NN, IE_ADDR);
    op_only(OP_LD_HL_A);
    ei_timer = load_ptr;
    op_only(OP_EI);
    spin_timer = load_ptr;
    op_with_word(OP_JP_NN, spin_timer);
    mem_image[READ_ADDR] = READBACK;
  endtask

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("FAILED t=%0t %s expected %h got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_true(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      $display("ERROR t=%0t %s", $time, what);
      errors++;
    end
  endtask

  task automatic abort_run(input string reason);
    errors++;
    $display("TIMEOUT t=%0t %s", $time, reason);
    $display("tests: %0d, checks: %0d, errors: %0d", tests_done, checks, errors);
    $display("sim failed");
    $finish;
  endtask

  task automatic next_event(output bus_event_t ev);
    int waited;
    waited = 0;
    while (events.size() == 0) begin
      if (waited == EVENT_TIMEOUT) abort_run("no transfer on mem within the timeout");
      @(posedge clk);
      waited++;
    end
    ev = events.pop_front();
  endtask

  task automatic expect_read(input logic [15:0] addr);
    bus_event_t ev;
    next_event(ev);
    check_true(!ev.is_write, $sformatf("write to %h where a read of %h was due",
                                       ev.addr, addr));
    check_value("mem.addr", addr, ev.addr);
  endtask

  // Reads on the way are fine, writes are not
  task automatic skip_to_read(input logic [15:0] addr);
    bus_event_t ev;
    int         seen;
    logic       found;
    seen  = 0;
    found = 1'b0;
    while (!found) begin
      if (seen == SEARCH_LIMIT) abort_run($sformatf("read of %h never came", addr));
      next_event(ev);
      seen++;
      check_true(!ev.is_write, $sformatf("unexpected write of %h to %h on mem",
                                         ev.data, ev.addr));
      found = !ev.is_write && ev.addr == addr;
    end
  endtask

  task automatic expect_write(input logic [15:0] addr, input logic [7:0] data);
    bus_event_t ev;
    int         seen;
    seen = 0;
    ev   = '0;
    while (!ev.is_write) begin
      if (seen == SEARCH_LIMIT) abort_run($sformatf("write to %h never came", addr));
      next_event(ev);
      seen++;
    end
    check_value("mem.addr", addr, ev.addr);
    check_value("mem.wdata", {8'h00, data}, {8'h00, ev.data});
  endtask

  task automatic irq_pulse(input irq_req_t req);
    @(posedge clk);
    #2 irq = req;
    @(posedge clk);
    #2 irq = '0;
  endtask

  // Push of the old PC, then the fetch from the vector
  task automatic check_entry(input logic [15:0] old_pc, input logic [2:0] idx);
    expect_write(exp_sp - 16'd1, old_pc[15:8]);
    expect_write(exp_sp - 16'd2, old_pc[7:0]);
    exp_sp = exp_sp - 16'd2;
    expect_read(vector_addr(idx));
  endtask

  task automatic end_test(input string name);
    tests_done++;
    $display("test %0d %s: %s", tests_done, name, (errors == test_errors) ? "ok" : "errors");
    test_errors = errors;
  endtask

  initial begin
    reset           = 1'b1;
    irq             = '0;
    prev_read       = 1'b0;
    prev_write      = 1'b0;
    errors          = 0;
    checks          = 0;
    tests_done      = 0;
    test_errors     = 0;
    skipped_fetches = 0;
    seed            = 32'h0fc6_ff01;
    exp_sp          = RESET_SP;
    timer_req       = '0;
    timer_req.timer = 1'b1;
    pair_req        = '0;
    pair_req.vblank = 1'b1;
    pair_req.joypad = 1'b1;
    load_program();
    repeat (16) @(posedge clk);
    #2 reset = 1'b0;

    expect_read(16'h0000);
    end_test("reset and first fetch");

    exp_a = N1 + N2;
    expect_write(16'hC000, exp_a);  // Also the first write of the run
    exp_a = exp_a + 8'd1;
    expect_write(16'hC001, exp_a);
    end_test("load and add");

    exp_a = READBACK + 8'd1;
    expect_write(16'hC002, exp_a);
    end_test("read back");

    skip_to_read(jp_operand_hi);
    expect_read(JUMP_TARGET);
    check_true(skipped_fetches == 0, "fetch from the bytes skipped by the jump");
    end_test("jump");

    skip_to_read(ei_main);  // IE store must stay off mem
    pulse_delay = $random(seed) & 31;
    repeat (pulse_delay) @(posedge clk);
    irq_pulse(timer_req);
    check_entry(spin_main, TIMER_IDX);
    expect_write(16'hC010, TIMER_MARK);
    expect_write(16'hC011, 8'hE0);  // Upper bits set, timer flag acknowledged
    end_test("interrupt window and entry");

    skip_to_read(ei_timer);
    irq_pulse(pair_req);
    check_entry(spin_timer, VBLANK_IDX);
    expect_write(16'hC012, VBLANK_MARK);
    end_test("priority");

    check_true(dut.core.props.fail_count == 0, "bus protocol assertion failed");
    $display("tests: %0d, checks: %0d, errors: %0d", tests_done, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* gb_cpu_top.f */
src/sm83_types_pkg.sv
src/sm83_ucode_pkg.sv
src/sm83_alu.sv
src/interrupt_ctrl.sv
src/gb_bus_map.sv
src/sm83_core.sv
src/gb_cpu_top.sv
verif/gb_cpu_props.sv
verif/gb_cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the gb_cpu testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f gb_cpu_top.f --top-module gb_cpu_tb -o gb_cpu_sim

output=$(./obj_dir/gb_cpu_sim) || true
echo "$output"

echo "$output" | grep -qx "sim passed"
